//--- design/xbar_pkg.sv
// Crossbar package
// Field widths, vector typedefs, packet struct, arbiter mode enum
`default_nettype none

package xbar_pkg;

   //####################
   // Field widths
   //####################

   localparam int CW        = 16;   // Command
   localparam int AW        = 32;   // Destination and source address
   localparam int DW        = 64;   // Data

   // Port index width
   // Top level N must stay at or below 2**PORT_BITS
   localparam int PORT_BITS = 2;

   //####################
   // Vector types
   //####################

   typedef logic [CW-1:0]        cmd_t;
   typedef logic [AW-1:0]        addr_t;
   typedef logic [DW-1:0]        data_t;
   typedef logic [PORT_BITS-1:0] port_t;   // Output or input index

   //####################
   // Packet
   //####################

   // One UMI style message, 144 bits
   // Destination port sits in the top PORT_BITS of dstaddr
   // Source identity by convention in the top PORT_BITS of srcaddr
   typedef struct packed
   {
      cmd_t  cmd;       // Opcode, passed through untouched
      addr_t dstaddr;   // Routing field
      addr_t srcaddr;   // Return address
      data_t data;      // Payload
   } umi_pkt_t;

   //####################
   // Arbiter mode
   //####################

   // Codes 2 and 3 fall back to fixed priority
   typedef enum logic [1:0]
   {
      ARB_FIXED = 2'd0,   // Lowest input wins
      ARB_RR    = 2'd1    // Rotating priority
   } arb_mode_t;

endpackage

`default_nettype wire

//--- design/xbar_arbiter.sv
// Per-output arbiter
// Fixed or round-robin grant, lock under back-pressure, rotating pointer
`timescale 1ns/100ps
`default_nettype none

module xbar_arbiter
#(
   parameter int N = 4                         // Number of requesters
)
(
   input  logic                clk,
   input  logic                arst_n,
   input  xbar_pkg::arb_mode_t mode,           // ARB_RR or fixed
   input  logic [N-1:0]        requests,       // Unmasked column
   input  logic                accept,         // Output transfer this cycle
   output logic [N-1:0]        grants          // One-hot or zero
);
   import xbar_pkg::*;

   logic [N-1:0] fresh_grants;   // Result of a new search
   logic [N-1:0] lock_grants;    // Grant of the previous cycle
   logic         locked;         // Previous grant still waiting
   port_t        rr_ptr;         // First index searched in RR mode
   port_t        winner;         // Encoded grant

   //####################
   // Search
   //####################

   always_comb
   begin
      int   idx;
      logic found;
      fresh_grants = '0;
      found        = 1'b0;
      for (int k = 0; k < N; k++)
      begin
         idx = (mode == ARB_RR) ? int'(rr_ptr) + k : k;   // Fixed starts at 0
         if (idx >= N)
            idx = idx - N;                               // Wrap around
         if (!found && requests[idx])
         begin
            fresh_grants[idx] = 1'b1;
            found             = 1'b1;
         end
      end
   end

   // Hold the old grant while its request is still up
   assign grants = (locked && |(lock_grants & requests)) ? lock_grants : fresh_grants;

   always_comb
   begin
      winner = '0;
      for (int k = 0; k < N; k++)
         if (grants[k])
            winner = port_t'(k);
   end

   //####################
   // State
   //####################

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         locked      <= 1'b0;
         lock_grants <= '0;
         rr_ptr      <= '0;   // Input 0 first
      end
      else
      begin
         locked      <= |grants & ~accept;   // Granted but stalled
         lock_grants <= grants;
         if (accept)
            rr_ptr <= (winner == port_t'(N-1)) ? '0 : winner + port_t'(1);   // Just past winner
      end
   end

   // Grant legal against this cycle's requests
   a_grant_legal : assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(grants) && ((grants & ~requests) == '0));

endmodule

`default_nettype wire

//--- design/xbar_ingress.sv
// Ingress buffer for one input port
// Two-entry circular FIFO, head destination decode to a one-hot request
`timescale 1ns/100ps
`default_nettype none

module xbar_ingress
#(
   parameter int N = 4                      // Number of output ports
)
(
   input  logic               clk,
   input  logic               arst_n,
   // Source side
   input  logic               in_valid,
   output logic               in_ready,
   input  xbar_pkg::umi_pkt_t in_pkt,
   // Switch side
   output logic               head_valid,
   output logic [N-1:0]       head_req,     // One-hot output request
   output xbar_pkg::umi_pkt_t head_pkt,
   input  logic               pop           // Head leaves this cycle
);
   import xbar_pkg::*;

   umi_pkt_t   mem [2];   // Storage, payload only
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;     // 0, 1 or 2 entries
   logic       push;
   port_t      dst;       // Head destination port

   //####################
   // Handshake
   //####################

   assign in_ready = (count != 2'd2);         // Room for one more
   assign push     = in_valid & in_ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_pkt;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;   // Idle or pass through
         endcase
      end
   end

   //####################
   // Head decode
   //####################

   assign head_valid = (count != 2'd0);
   assign head_pkt   = mem[rd_ptr];
   assign dst        = head_pkt.dstaddr[AW-1 -: PORT_BITS];   // Top bits pick the output

   always_comb
   begin
      head_req = '0;
      if (int'(dst) < N)   // Out of range leaves it zero
         head_req[dst] = 1'b1;
   end

   // Switch only pops a head that exists
   a_pop_nonempty : assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> head_valid);

   // Accepted write never lands on an unread entry
   a_push_not_full : assert property (@(posedge clk) disable iff (!arst_n)
      push |-> (wr_ptr != rd_ptr) || (count == 2'd0));

endmodule

`default_nettype wire

//--- design/xbar_switch.sv
// Crossbar core
// Request matrix with mask, one arbiter per output, AND-OR output muxes,
// pop and drop per input
`timescale 1ns/100ps
`default_nettype none

module xbar_switch
#(
   parameter int N = 4                                   // Ports per side
)
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  xbar_pkg::arb_mode_t        mode,
   input  logic [N*N-1:0]             mask,         // Bit out*N+in blocks the pair
   // Ingress heads
   input  logic [N-1:0]               head_valid,
   input  logic [N-1:0][N-1:0]        head_req,     // [in][out]
   input  xbar_pkg::umi_pkt_t [N-1:0] head_pkt,
   output logic [N-1:0]               pop,
   output logic [N-1:0]               drop,         // Masked or unroutable head
   // Outputs
   output logic [N-1:0]               out_valid,
   input  logic [N-1:0]               out_ready,
   output xbar_pkg::umi_pkt_t [N-1:0] out_pkt
);
   import xbar_pkg::*;

   logic [N-1:0][N-1:0] req_row;    // [in][out] valid and unmasked
   logic [N-1:0][N-1:0] req_col;    // [out][in] arbiter view
   logic [N-1:0][N-1:0] gnt;        // [out][in]
   logic [N-1:0][N-1:0] gnt_row;    // [in][out]
   logic [N-1:0]        accept;     // Output transfer

   //####################
   // Request matrix
   //####################

   always_comb
   begin
      for (int i = 0; i < N; i++)
         for (int o = 0; o < N; o++)
         begin
            req_row[i][o] = head_valid[i] & head_req[i][o] & ~mask[o*N+i];
            req_col[o][i] = req_row[i][o];
            gnt_row[i][o] = gnt[o][i];   // Transpose for pop
         end
   end

   //####################
   // Arbiters and muxes
   //####################

   for (genvar o = 0; o < N; o++)
   begin : g_out
      xbar_arbiter #(.N(N)) u_arb
      (
         .clk      (clk),
         .arst_n   (arst_n),
         .mode     (mode),
         .requests (req_col[o]),
         .accept   (accept[o]),
         .grants   (gnt[o])
      );

      assign out_valid[o] = |gnt[o];
      assign accept[o]    = out_valid[o] & out_ready[o];

      always_comb
      begin
         logic [$bits(umi_pkt_t)-1:0] sel;
         sel = '0;
         for (int i = 0; i < N; i++)
            sel = sel | ({$bits(umi_pkt_t){gnt[o][i]}} & head_pkt[i]);   // AND-OR select
         out_pkt[o] = umi_pkt_t'(sel);
      end

      // Stalled output keeps its packet
      a_out_stable : assert property (@(posedge clk) disable iff (!arst_n)
         (out_valid[o] && !out_ready[o]) |=> out_valid[o] && $stable(out_pkt[o]));
   end

   //####################
   // Pop and drop
   //####################

   for (genvar i = 0; i < N; i++)
   begin : g_in
      assign drop[i] = head_valid[i] & ~|req_row[i];             // Nowhere to go
      assign pop[i]  = drop[i] | |(gnt_row[i] & out_ready);      // Sent or discarded

      // One head, one output at most
      a_single_grant : assert property (@(posedge clk) disable iff (!arst_n)
         $onehot0(gnt_row[i]));
   end

endmodule

`default_nettype wire

//--- design/xbar_top.sv
// Crossbar top level
// N ingress buffers feeding one switch core
`timescale 1ns/100ps
`default_nettype none

module xbar_top
#(
   parameter int N = 4                                    // Ports, at most 2**PORT_BITS
)
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  xbar_pkg::arb_mode_t        mode,        // Arbitration scheme
   input  logic [N*N-1:0]             mask,        // Bit out*N+in blocks the pair
   // Inputs
   input  logic [N-1:0]               in_valid,
   output logic [N-1:0]               in_ready,
   input  xbar_pkg::umi_pkt_t [N-1:0] in_pkt,
   output logic [N-1:0]               drop,        // One pulse per dropped packet
   // Outputs
   output logic [N-1:0]               out_valid,
   input  logic [N-1:0]               out_ready,
   output xbar_pkg::umi_pkt_t [N-1:0] out_pkt
);
   import xbar_pkg::*;

   logic [N-1:0]        head_valid;
   logic [N-1:0][N-1:0] head_req;     // [in][out]
   umi_pkt_t [N-1:0]    head_pkt;
   logic [N-1:0]        pop;

   //####################
   // Ingress
   //####################

   for (genvar i = 0; i < N; i++)
   begin : g_ing
      xbar_ingress #(.N(N)) u_ing
      (
         .clk        (clk),
         .arst_n     (arst_n),
         .in_valid   (in_valid[i]),
         .in_ready   (in_ready[i]),
         .in_pkt     (in_pkt[i]),
         .head_valid (head_valid[i]),
         .head_req   (head_req[i]),
         .head_pkt   (head_pkt[i]),
         .pop        (pop[i])
      );
   end

   //####################
   // Switch
   //####################

   xbar_switch #(.N(N)) u_sw
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .mode       (mode),
      .mask       (mask),
      .head_valid (head_valid),
      .head_req   (head_req),
      .head_pkt   (head_pkt),
      .pop        (pop),
      .drop       (drop),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_pkt    (out_pkt)
   );

endmodule

`default_nettype wire

//--- bench/xbar_tb.sv
// Crossbar testbench
// Clock and reset, stimulus table, per-source senders, per-output scoreboard,
// drop counting, round-robin order and fixed-priority checks
`timescale 1ns/100ps
`default_nettype none

module xbar_tb;
   import xbar_pkg::*;

   localparam int N       = 4;
   localparam int LOW     = AW - PORT_BITS;   // Address bits below the port field
   localparam int TIMEOUT = 2000;             // Cycles allowed per wait

   // One table row
   typedef struct packed
   {
      port_t          src;
      port_t          dst;
      data_t          data;
      arb_mode_t      mode;
      logic [N*N-1:0] mask;   // Same for every row of a test
   } stim_t;

   logic                clk;
   logic                arst_n;
   arb_mode_t           mode;
   logic [N*N-1:0]      mask;
   logic [N-1:0]        in_valid;
   logic [N-1:0]        in_ready;
   umi_pkt_t [N-1:0]    in_pkt;
   logic [N-1:0]        drop;
   logic [N-1:0]        out_valid;
   logic [N-1:0]        out_ready;
   umi_pkt_t [N-1:0]    out_pkt;

   stim_t    stim_q [$];           // Table rows
   string    name_q [$];           // Test name per row
   umi_pkt_t send_q [N][$];        // Per source, in send order
   umi_pkt_t exp_q [N*N][$];       // Index out*N+src
   int       drop_exp [N];
   int       drop_seen [N];
   logic [N-1:0] held;             // Output stalled last cycle
   umi_pkt_t held_pkt [N];
   string    cur_name;
   logic     rand_ready;           // Random out_ready gaps
   logic     check_rr;
   logic     check_prio;
   logic     rr_have;              // First RR grant seen
   port_t    rr_last;
   int       idx;

   xbar_top #(.N(N)) UUT
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .mode      (mode),
      .mask      (mask),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_pkt    (in_pkt),
      .drop      (drop),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_pkt   (out_pkt)
   );

   always #4 clk = ~clk;   // 8 ns period

   //####################
   // Helpers
   //####################

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Stopped at first error");
   endtask

   function automatic data_t rand_data();
      return {$urandom(), $urandom()};
   endfunction

   task automatic add_row(input string name, input int src, input int dst,
                          input arb_mode_t row_mode, input logic [N*N-1:0] row_mask);
      stim_t row;
      row.src  = port_t'(src);
      row.dst  = port_t'(dst);
      row.data = rand_data();
      row.mode = row_mode;
      row.mask = row_mask;
      stim_q.push_back(row);
      name_q.push_back(name);
   endtask

   // Source and destination carried in the top address bits
   task automatic queue_row(input stim_t row, input int seq);
      umi_pkt_t pkt;
      int       pair;
      pkt.cmd     = cmd_t'(seq);
      pkt.dstaddr = {row.dst, LOW'(seq * 16)};
      pkt.srcaddr = {row.src, LOW'(seq)};
      pkt.data    = row.data;
      pair        = int'(row.dst) * N + int'(row.src);
      send_q[row.src].push_back(pkt);
      if (row.mask[pair])
         drop_exp[row.src]++;              // Masked pair ends in a drop
      else
         exp_q[pair].push_back(pkt);
   endtask

   function automatic bit drained();
      for (int q = 0; q < N*N; q++)
         if (exp_q[q].size() != 0)
            return 1'b0;
      for (int i = 0; i < N; i++)
         if (drop_seen[i] != drop_exp[i])
            return 1'b0;
      return 1'b1;
   endfunction

   // Sends one source's queue back to back
   task automatic send_queue(input int src);
      int   waited;
      logic taken;
      while (send_q[src].size() > 0)
      begin
         @(negedge clk);
         in_valid[src] = 1'b1;
         in_pkt[src]   = send_q[src].pop_front();
         waited        = 0;
         taken         = 1'b0;
         while (!taken)
         begin
            #2;
            taken = in_ready[src];      // Transfer on the coming edge
            if (!taken)
            begin
               waited++;
               assert (waited < TIMEOUT)
               else
                  abort_run($sformatf("Timeout waiting for in_ready on input %0d", src));
               @(negedge clk);
            end
         end
      end
      @(negedge clk);
      in_valid[src] = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (!drained())
      begin
         @(negedge clk);
         waited++;
         assert (waited < TIMEOUT)
         else
            abort_run($sformatf("Timeout waiting for test %s to drain", cur_name));
      end
   endtask

   //####################
   // Output side
   //####################

   always @(negedge clk)
      out_ready = rand_ready ? (4'($urandom()) | 4'($urandom())) : '1;   // About 3/4 high

   // Samples 2 ns before the rising edge
   always
   begin
      port_t    src;
      umi_pkt_t exp_pkt;
      @(negedge clk);
      #2;
      if (arst_n)
      begin
         for (int o = 0; o < N; o++)
         begin
            if (held[o])
            begin
               assert (out_valid[o])
               else
                  abort_run($sformatf("Output %0d let go of a stalled packet", o));
               assert (out_pkt[o] === held_pkt[o])
               else
                  abort_run($sformatf("MISMATCH %s expected %h actual %h",
                                      cur_name, held_pkt[o], out_pkt[o]));
            end
            held[o]     = out_valid[o] && !out_ready[o];
            held_pkt[o] = out_pkt[o];
            if (out_valid[o] && out_ready[o])
            begin
               src = out_pkt[o].srcaddr[AW-1 -: PORT_BITS];
               assert (exp_q[o*N + int'(src)].size() > 0)
               else
                  abort_run($sformatf("Unexpected packet on output %0d from input %0d",
                                      o, src));
               exp_pkt = exp_q[o*N + int'(src)].pop_front();
               assert (out_pkt[o] === exp_pkt)
               else
                  abort_run($sformatf("MISMATCH %s expected %h actual %h",
                                      cur_name, exp_pkt, out_pkt[o]));
               if (check_rr && o == 0)
               begin
                  if (rr_have)
                     assert (src == port_t'(rr_last + port_t'(1)))   // Cyclic order
                     else
                        abort_run($sformatf("MISMATCH %s expected %0d actual %0d",
                                            cur_name, port_t'(rr_last + port_t'(1)), src));
                  rr_last = src;
                  rr_have = 1'b1;
               end
               if (check_prio && o == 1 && src == port_t'(N-1))
                  assert (exp_q[1*N + 0].size() == 0)
                  else
                     abort_run("Input 3 packet overtook the input 0 backlog on output 1");
            end
         end
         for (int i = 0; i < N; i++)
            if (drop[i])
            begin
               drop_seen[i]++;
               assert (drop_seen[i] <= drop_exp[i])
               else
                  abort_run($sformatf("Unexpected drop pulse on input %0d", i));
            end
      end
   end

   //####################
   // Main sequence
   //####################

   initial
   begin
      void'($urandom(32'h2516_285a));
      clk        = 1'b0;
      arst_n     = 1'b0;
      mode       = ARB_FIXED;
      mask       = '0;
      in_valid   = '0;
      in_pkt     = '0;
      out_ready  = '1;
      held       = '0;
      rand_ready = 1'b0;
      check_rr   = 1'b0;
      check_prio = 1'b0;
      rr_have    = 1'b0;
      rr_last    = '0;
      cur_name   = "reset";
      for (int i = 0; i < N; i++)
      begin
         drop_exp[i]  = 0;
         drop_seen[i] = 0;
      end

      // Every source to every destination
      for (int s = 0; s < N; s++)
         for (int d = 0; d < N; d++)
            add_row("routing", s, d, ARB_FIXED, '0);
      for (int r = 0; r < 32; r++)
         add_row("backpressure", int'($urandom_range(N-1)), int'($urandom_range(N-1)),
                 ARB_RR, '0);
      // Pairs out 2 / in 1 and out 0 / in 3 blocked
      add_row("masking", 1, 2, ARB_FIXED, 16'h0208);
      add_row("masking", 1, 3, ARB_FIXED, 16'h0208);
      add_row("masking", 1, 2, ARB_FIXED, 16'h0208);
      add_row("masking", 3, 0, ARB_FIXED, 16'h0208);
      add_row("masking", 3, 1, ARB_FIXED, 16'h0208);
      add_row("masking", 0, 2, ARB_FIXED, 16'h0208);
      add_row("masking", 2, 0, ARB_FIXED, 16'h0208);
      for (int r = 0; r < 3; r++)
         for (int s = 0; s < N; s++)
            add_row("round_robin", s, 0, ARB_RR, '0);
      for (int r = 0; r < 4; r++)
         add_row("fixed_prio", 0, 1, ARB_FIXED, '0);
      for (int r = 0; r < 3; r++)
         add_row("fixed_prio", 3, 1, ARB_FIXED, '0);

      repeat (4) @(negedge clk);
      arst_n = 1'b1;

      idx = 0;
      while (idx < stim_q.size())
      begin
         cur_name = name_q[idx];
         @(negedge clk);
         mode       = stim_q[idx].mode;
         mask       = stim_q[idx].mask;
         rand_ready = !(cur_name == "round_robin" || cur_name == "fixed_prio");
         check_rr   = (cur_name == "round_robin");
         check_prio = (cur_name == "fixed_prio");
         rr_have    = 1'b0;
         while (idx < stim_q.size() && name_q[idx] == cur_name)
         begin
            queue_row(stim_q[idx], idx);
            idx++;
         end
         fork
            send_queue(0);
            send_queue(1);
            send_queue(2);
            send_queue(3);
         join
         wait_drain();
      end

      repeat (10) @(negedge clk);   // Catch stray traffic
      if (drained() && out_valid == '0 && in_ready == '1)
      begin
         $display("Regression passed");
         $finish;
      end
      else
         abort_run("Traffic left in the crossbar at the end of the run");
   end

endmodule

`default_nettype wire

//--- list.f
design/xbar_pkg.sv
design/xbar_arbiter.sv
design/xbar_ingress.sv
design/xbar_switch.sv
design/xbar_top.sv
bench/xbar_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the crossbar regression with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module xbar_tb -f list.f -o xbar_sim \
   > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/xbar_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Regression passed" "$SIM_LOG"; then
   exit 0
fi
exit 1
